// File: Makefile
SIM      := verilator
TOP      := tb_frame_dump
FILELIST := build.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG := Something failed
PASS_MSG := Everything OK

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
hdl/frame_pkg.sv
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/pixel_sender.sv
hdl/word_fifo.sv
hdl/frame_reader.sv
hdl/frame_dump_top.sv
tests/dump_props_chk.sv
tests/dump_monitor.sv
tests/tb_frame_dump.sv

// File: hdl/frame_dump_top.sv
/*
 frame dump over RS-232, reader -> word FIFO -> pixel sender
 - frame store is external, synchronous, one cycle read latency
 - FRAME_WIDTH multiple of 4, FIFO_DEPTH a power of two
 - busy stays high from the save until the last stop bit
*/
`timescale 1ns/1ns

module frame_dump_top import frame_pkg::*; #(
   parameter int FRAME_WIDTH  = 16,
   parameter int FRAME_HEIGHT = 4,
   parameter int CLKS_PER_BIT = 8,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              save,
   output logic [ADDR_W-1:0] mem_addr,
   output logic              mem_rd,
   input  mem_word_t         mem_rdata,
   output logic              txd,
   output logic              busy
);

   localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

   mem_word_t        rd_word;
   logic             rd_valid;
   logic             rd_ready;
   mem_word_t        fifo_word;
   logic             fifo_valid;
   logic             fifo_ready;
   logic [LVL_W-1:0] fifo_level;
   logic             scan_done;
   logic             done;

   //////////////////////////////
   // producer
   //////////////////////////////
   frame_reader #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_frame_reader (
      .clk        (clk),
      .rst_n      (rst_n),
      .save       (save),
      .done       (done),
      .mem_addr   (mem_addr),
      .mem_rd     (mem_rd),
      .mem_rdata  (mem_rdata),
      .rd_word    (rd_word),
      .rd_valid   (rd_valid),
      .rd_ready   (rd_ready),
      .fifo_level (fifo_level),
      .scan_done  (scan_done),
      .busy       (busy)
   );

   // buffer, level feeds back for the read credit
   word_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_word_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_word   (rd_word),
      .in_valid  (rd_valid),
      .in_ready  (rd_ready),
      .out_word  (fifo_word),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready),
      .level     (fifo_level)
   );

   //////////////////////////////
   // consumer
   //////////////////////////////
   pixel_sender #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_pixel_sender (
      .clk        (clk),
      .rst_n      (rst_n),
      .fifo_word  (fifo_word),
      .fifo_valid (fifo_valid),
      .fifo_ready (fifo_ready),
      .scan_done  (scan_done),
      .fifo_level (fifo_level),
      .txd        (txd),
      .done       (done)
   );

endmodule

// File: hdl/frame_pkg.sv
/*
 frame store geometry and pixel byte order for the dump path
 - one 32-bit memory word holds four 8-bit grayscale pixels
 - word addresses are 19 bits wide, as on the labkit ZBT bank
 - bytes leave the link as lane 0, then 3, 2, 1 of each word
*/
package frame_pkg;

   // one memory word, four pixels packed
   typedef logic [31:0] mem_word_t;

   // one grayscale pixel
   typedef logic [7:0] pixel_t;

   localparam int PIXELS_PER_WORD = 4;

   // word address width of the frame store
   localparam int ADDR_W = 19;

   // byte lane inside a memory word
   typedef logic [1:0] byte_lane_t;

   // lane sent in each slot of a word
   // slot 0 -> bits 7:0, then 31:24, 23:16, 15:8
   function automatic byte_lane_t send_order(input logic [1:0] slot);
      case (slot)
         2'd0:    return 2'd0;
         2'd1:    return 2'd3;
         2'd2:    return 2'd2;
         default: return 2'd1;
      endcase
   endfunction

endpackage

// File: hdl/frame_reader.sv
/*
 scans the locked frame store and pushes memory words downstream
 - memory has a fixed read latency of one cycle
 - reads are issued only while the FIFO has room for them all
 - a save during a dump is ignored, busy ends on the done pulse
 - FRAME_WIDTH must be a multiple of 4
*/
`timescale 1ns/1ns

module frame_reader import frame_pkg::*; #(
   parameter int FRAME_WIDTH  = 16,
   parameter int FRAME_HEIGHT = 4,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 save,
   input  logic                                 done,
   output logic [ADDR_W-1:0]                    mem_addr,
   output logic                                 mem_rd,
   input  mem_word_t                            mem_rdata,
   output mem_word_t                            rd_word,
   output logic                                 rd_valid,
   input  logic                                 rd_ready,
   input  logic [$clog2(FIFO_DEPTH + 1)-1:0]    fifo_level,
   output logic                                 scan_done,
   output logic                                 busy
);

   localparam int WORDS_PER_LINE = FRAME_WIDTH / PIXELS_PER_WORD;
   localparam int WORD_W = (WORDS_PER_LINE > 1) ? $clog2(WORDS_PER_LINE) : 1;
   localparam int LINE_W = (FRAME_HEIGHT > 1) ? $clog2(FRAME_HEIGHT) : 1;
   localparam int LVL_W  = $clog2(FIFO_DEPTH + 1);
   localparam int CR_W   = LVL_W + 1;

   logic [WORD_W-1:0] word_idx;
   logic [LINE_W-1:0] line_idx;
   logic              issued_all;
   logic              rd_pend;
   logic [CR_W-1:0]   credit_used;
   logic              last_word;
   logic              last_line;

   //////////////////////////////
   // read credit
   //////////////////////////////

   // words already owed to the FIFO: stored, in flight or held here
   assign credit_used = CR_W'(fifo_level) + CR_W'(rd_pend) + CR_W'(rd_valid);
   assign mem_rd = busy & ~issued_all & (credit_used < CR_W'(FIFO_DEPTH));

   // row times words per line plus column, same as {row, col} for 2^n widths
   assign mem_addr = ADDR_W'(line_idx * WORDS_PER_LINE) + ADDR_W'(word_idx);

   assign last_word = (word_idx == WORD_W'(WORDS_PER_LINE - 1));
   assign last_line = (line_idx == LINE_W'(FRAME_HEIGHT - 1));

   // last word has left this block once nothing is pending or held
   assign scan_done = issued_all & ~rd_pend & ~rd_valid;

   //////////////////////////////
   // frame lock and scan
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         issued_all <= 1'b0;
         word_idx   <= '0;
         line_idx   <= '0;
      end else if (done) begin
         // frame sent, unlock the store
         busy       <= 1'b0;
         issued_all <= 1'b0;
      end else if (save && !busy) begin
         busy       <= 1'b1;
         issued_all <= 1'b0;
         word_idx   <= '0;
         line_idx   <= '0;
      end else if (mem_rd) begin
         if (last_word) begin
            word_idx <= '0;
            if (last_line)
               issued_all <= 1'b1;
            else
               line_idx <= line_idx + 1'b1;
         end else begin
            word_idx <= word_idx + 1'b1;
         end
      end
   end

   // read return pipeline, data on mem_rdata the cycle after mem_rd
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend  <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         rd_pend <= mem_rd;
         if (rd_pend)
            rd_valid <= 1'b1;
         else if (rd_ready)
            rd_valid <= 1'b0;
      end
   end

   // holding register for the returned word
   always_ff @(posedge clk) begin
      if (rd_pend)
         rd_word <= mem_rdata;
   end

endmodule

// File: hdl/pixel_sender.sv
/*
 unpacks buffered words into pixel bytes for the serial link
 - a new word is taken only after its four bytes went to the UART
 - byte order per word follows send_order
 - done pulses once, after the last stop bit of the frame
*/
`timescale 1ns/1ns

module pixel_sender import frame_pkg::*; #(
   parameter int CLKS_PER_BIT = 8,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  mem_word_t                         fifo_word,
   input  logic                              fifo_valid,
   output logic                              fifo_ready,
   input  logic                              scan_done,
   input  logic [$clog2(FIFO_DEPTH + 1)-1:0] fifo_level,
   output logic                              txd,
   output logic                              done
);

   mem_word_t  word_reg;
   logic       have_word;
   logic [1:0] slot;
   pixel_t     tx_byte;
   logic       tx_valid;
   logic       tx_ready;
   logic       tx_idle;
   logic       last_slot;
   logic       frame_empty;

   // word register free once all bytes are handed over
   assign fifo_ready = ~have_word;
   assign tx_valid   = have_word;

   // lane picked by the slot, times 8 for the bit offset
   assign tx_byte   = word_reg[{send_order(slot), 3'b000} +: 8];
   assign last_slot = (slot == 2'(PIXELS_PER_WORD - 1));

   // nothing left anywhere and the line has gone quiet
   assign frame_empty = scan_done & (fifo_level == '0) & ~have_word & tx_idle;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         have_word <= 1'b0;
         slot      <= '0;
         done      <= 1'b0;
      end else begin
         if (fifo_valid && fifo_ready) begin
            have_word <= 1'b1;
            slot      <= '0;
         end else if (tx_valid && tx_ready) begin
            if (last_slot)
               have_word <= 1'b0;
            else
               slot <= slot + 1'b1;
         end
         // one cycle pulse, the reader drops scan_done right after
         done <= frame_empty & ~done;
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_valid && fifo_ready)
         word_reg <= fifo_word;
   end

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_tx (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_byte  (tx_byte),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .txd      (txd),
      .tx_idle  (tx_idle)
   );

endmodule

// File: hdl/uart_pkg.sv
/*
 RS-232 framing for the pixel link
 - 8N1 framing, one start bit, eight data bits, one stop bit
 - no parity bit is sent
 - line idles at the stop level
*/
package uart_pkg;

   // start bit pulls the line low
   localparam logic START_LEVEL = 1'b0;

   // stop bit and idle line are high
   localparam logic STOP_LEVEL = 1'b1;

   // data bits per character, lsb first
   localparam int DATA_BITS = 8;

   // transmitter FSM states
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

// File: hdl/uart_tx.sv
/*
 RS-232 transmitter, one byte at a time, 8N1
 - every bit lasts exactly CLKS_PER_BIT clocks
 - txd drops to the start level the cycle after a byte is accepted
 - tx_ready comes back at the end of the stop bit
*/
`timescale 1ns/1ns

module uart_tx import frame_pkg::*, uart_pkg::*; #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic   clk,
   input  logic   rst_n,
   input  pixel_t tx_byte,
   input  logic   tx_valid,
   output logic   tx_ready,
   output logic   txd,
   output logic   tx_idle
);

   localparam int TMR_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int IDX_W = $clog2(DATA_BITS);

   tx_state_t        state;
   logic [TMR_W-1:0] bit_timer;
   logic [IDX_W-1:0] bit_idx;
   pixel_t           shift_reg;
   logic             bit_end;
   logic             load;

   assign bit_end = (bit_timer == TMR_W'(CLKS_PER_BIT - 1));
   assign load    = tx_valid & tx_ready;
   assign tx_idle = (state == TX_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= TX_IDLE;
         bit_timer <= '0;
         bit_idx   <= '0;
         txd       <= STOP_LEVEL;
         tx_ready  <= 1'b1;
      end else begin
         // bit timer runs in every state but idle
         if (state == TX_IDLE || bit_end)
            bit_timer <= '0;
         else
            bit_timer <= bit_timer + 1'b1;
         case (state)
            TX_IDLE: if (load) begin
               state    <= TX_START;
               txd      <= START_LEVEL;
               tx_ready <= 1'b0;
            end
            TX_START: if (bit_end) begin
               state   <= TX_DATA;
               txd     <= shift_reg[0];
               bit_idx <= '0;
            end
            TX_DATA: if (bit_end) begin
               if (bit_idx == IDX_W'(DATA_BITS - 1)) begin
                  state <= TX_STOP;
                  txd   <= STOP_LEVEL;
               end else begin
                  bit_idx <= bit_idx + 1'b1;
                  txd     <= shift_reg[0];
               end
            end
            default: if (bit_end) begin
               state    <= TX_IDLE;
               tx_ready <= 1'b1;
            end
         endcase
      end
   end

   // lsb first, shift on every bit boundary before the stop bit
   always_ff @(posedge clk) begin
      if (load)
         shift_reg <= tx_byte;
      else if (bit_end && (state == TX_START || state == TX_DATA))
         shift_reg <= shift_reg >> 1;
   end

endmodule

// File: hdl/word_fifo.sv
/*
 word buffer between the frame reader and the pixel sender
 - FIFO_DEPTH is a power of two, at least 2
 - head word sits in an output register, level counts it too
 - a pushed word shows on out_valid one cycle later at the earliest
*/
`timescale 1ns/1ns

module word_fifo import frame_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  mem_word_t                         in_word,
   input  logic                              in_valid,
   output logic                              in_ready,
   output mem_word_t                         out_word,
   output logic                              out_valid,
   input  logic                              out_ready,
   output logic [$clog2(FIFO_DEPTH + 1)-1:0] level
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

   mem_word_t        mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             full;
   logic             push;
   logic             pop;
   logic             mem_empty;
   logic             load_out;
   logic             from_mem;
   logic             to_mem;

   assign full     = (level == LVL_W'(FIFO_DEPTH));
   assign in_ready = ~full;
   assign push     = in_valid & in_ready;
   assign pop      = out_valid & out_ready;

   // array holds at most depth-1 words, equal pointers mean empty
   assign mem_empty = (wr_ptr == rd_ptr);

   // output register free this cycle
   assign load_out = ~out_valid | pop;
   assign from_mem = load_out & ~mem_empty;
   // push goes straight to the output when nothing waits ahead of it
   assign to_mem   = push & ~(load_out & mem_empty);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         out_valid <= 1'b0;
         level     <= '0;
      end else begin
         if (to_mem)
            wr_ptr <= wr_ptr + 1'b1;
         if (from_mem)
            rd_ptr <= rd_ptr + 1'b1;
         if (load_out)
            out_valid <= from_mem | push;
         level <= level + LVL_W'(push) - LVL_W'(pop);
      end
   end

   // storage and head register
   always_ff @(posedge clk) begin
      if (to_mem)
         mem[wr_ptr] <= in_word;
      if (from_mem)
         out_word <= mem[rd_ptr];
      else if (load_out && push)
         out_word <= in_word;
   end

endmodule

// File: tests/dump_monitor.sv
/*
 watches txd and busy of the frame dump top
 - txd is sampled on the falling clock edge, 8N1 framing
 - every bit must hold for exactly CLKS_PER_BIT clocks
 - expected byte comes in on exp_byte, picked by byte_idx
*/
`timescale 1ns/1ns

module dump_monitor import frame_pkg::*; #(
   parameter int CLKS_PER_BIT = 8,
   parameter int FRAME_BYTES  = 64
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   save,
   input  logic   busy,
   input  logic   txd,
   input  pixel_t exp_byte,
   output int     byte_idx,
   output int     byte_count,
   output int     err_count,
   output int     frame_errs
);

   int dump_start;

   // position inside the running dump
   assign byte_idx = byte_count - dump_start;

   // framing faults are counted apart from data mismatches
   task automatic framing_error(input string what);
      $display("framing error at %0t ns: %s", $time, what);
      frame_errs++;
      err_count++;
   endtask

   // one character, the first start bit sample is already on txd
   task automatic read_char(output pixel_t data);
      logic first;
      logic mid;
      data = '0;
      mid  = 1'b1;
      for (int b = 0; b < 10; b++) begin
         for (int c = 0; c < CLKS_PER_BIT; c++) begin
            if (b != 0 || c != 0)
               @(negedge clk);
            if (c == 0)
               first = txd;
            else if (txd !== first)
               framing_error($sformatf("bit %0d shorter than %0d clocks", b, CLKS_PER_BIT));
            // value of the bit taken at its middle
            if (c == CLKS_PER_BIT / 2)
               mid = txd;
         end
         if (b >= 1 && b <= 8)
            data[b-1] = mid;
      end
      if (mid !== 1'b1)
         framing_error("stop bit not high");
   endtask

   //////////////////////////////
   // serial decoder
   //////////////////////////////
   initial begin
      pixel_t got;
      byte_count = 0;
      err_count  = 0;
      frame_errs = 0;
      forever begin
         @(negedge clk);
         if (rst_n && txd === 1'b0) begin
            read_char(got);
            if (got !== exp_byte) begin
               $display("FAILED at %0t ns: txd_byte expected 8'h%02h got 8'h%02h (byte %0d)",
                        $time, exp_byte, got, byte_idx);
               err_count++;
            end
            byte_count++;
         end
      end
   end

   //////////////////////////////
   // busy and dump length
   //////////////////////////////
   initial begin
      logic busy_q;
      logic save_q;
      busy_q     = 1'b0;
      save_q     = 1'b0;
      dump_start = 0;
      forever begin
         @(negedge clk);
         if (!rst_n) begin
            busy_q = 1'b0;
            save_q = 1'b0;
         end else begin
            if (busy && !busy_q && !save_q) begin
               $display("error at %0t ns: busy rose with no save", $time);
               err_count++;
            end
            if (save_q && !busy) begin
               $display("error at %0t ns: busy did not rise after save", $time);
               err_count++;
            end
            if (!busy && txd !== 1'b1) begin
               $display("error at %0t ns: txd left idle while not busy", $time);
               err_count++;
            end
            if (busy && !busy_q)
               dump_start = byte_count;
            // a dump has ended, exactly one frame must have gone out
            if (!busy && busy_q && (byte_count - dump_start) != FRAME_BYTES) begin
               $display("FAILED at %0t ns: dump_bytes expected %0d got %0d",
                        $time, FRAME_BYTES, byte_count - dump_start);
               err_count++;
            end
            // a save only counts when the store is unlocked
            save_q = save && !busy;
            busy_q = busy;
         end
      end
   end

endmodule

// File: tests/dump_props_chk.sv
/*
 bound checks on the transmitter and the word FIFO
 - one instance sits in uart_tx, one in word_fifo
 - inputs an instance does not use are tied to their quiet value
*/
`timescale 1ns/1ns

module dump_props_chk import uart_pkg::*; (
   input logic       clk,
   input logic       rst_n,
   input logic       hs_valid,
   input logic       hs_ready,
   input logic [7:0] hs_data,
   input logic       push,
   input logic       full,
   input logic       line,
   input tx_state_t  state
);

   // byte offered to the UART must hold until it is taken
   hold_byte: assert property (@(posedge clk) disable iff (!rst_n)
      (hs_valid && !hs_ready) |=> $stable(hs_data))
      else $error("tx_byte changed while tx_ready was low");

   // read credit keeps the reader from offering a word to a full FIFO
   no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> !full)
      else $error("word pushed while the FIFO was full");

   stop_high: assert property (@(posedge clk) disable iff (!rst_n)
      (state == TX_STOP) |-> (line == STOP_LEVEL))
      else $error("txd not at stop level during the stop bit");

endmodule

bind uart_tx dump_props_chk u_tx_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .hs_valid (tx_valid),
   .hs_ready (tx_ready),
   .hs_data  (tx_byte),
   .push     (1'b0),
   .full     (1'b0),
   .line     (txd),
   .state    (state)
);

bind word_fifo dump_props_chk u_fifo_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .hs_valid (1'b0),
   .hs_ready (1'b1),
   .hs_data  (8'h00),
   .push     (in_valid),
   .full     (full),
   .line     (1'b1),
   .state    (uart_pkg::TX_IDLE)
);

// File: tests/tb_frame_dump.sv
/*
 testbench for the frame dump path
 - 16 x 4 frame, 8 clocks per serial bit, 4 word FIFO
 - frame store model answers one cycle after mem_rd
 - word content is a fixed mix of its whole address
*/
`timescale 1ns/1ns

module tb_frame_dump import frame_pkg::*; ();

   localparam int FRAME_WIDTH  = 16;
   localparam int FRAME_HEIGHT = 4;
   localparam int CLKS_PER_BIT = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int FRAME_BYTES  = FRAME_WIDTH * FRAME_HEIGHT;
   // three dumps of ten bit times per byte, a quarter on top and some slack
   localparam int MAX_CYCLES = (3 * FRAME_BYTES * 10 * CLKS_PER_BIT) * 5 / 4 + 200;

   logic              clk;
   logic              rst_n;
   logic              save;
   logic [ADDR_W-1:0] mem_addr;
   logic              mem_rd;
   mem_word_t         mem_rdata;
   logic              txd;
   logic              busy;
   pixel_t            exp_byte;
   int                byte_idx;
   int                byte_count;
   int                err_count;
   int                frame_errs;
   int                cycles;
   int                tests_run;
   int                tests_failed;

   // frame store content
   function automatic mem_word_t word_at(input int unsigned addr);
      logic [31:0] a;
      a = addr;
      return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]} ^ 32'h5a5a_00ff;
   endfunction

   // byte n of a dump: words in address order, low byte then top down
   function automatic pixel_t ref_byte(input int unsigned n);
      mem_word_t   w;
      int unsigned slot;
      int unsigned lane;
      w    = word_at(n / PIXELS_PER_WORD);
      slot = n % PIXELS_PER_WORD;
      lane = (slot == 0) ? 0 : PIXELS_PER_WORD - slot;
      return w[lane*8 +: 8];
   endfunction

   assign exp_byte = ref_byte(byte_idx);

   frame_dump_top #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT),
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_frame_dump_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .save      (save),
      .mem_addr  (mem_addr),
      .mem_rd    (mem_rd),
      .mem_rdata (mem_rdata),
      .txd       (txd),
      .busy      (busy)
   );

   dump_monitor #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FRAME_BYTES  (FRAME_BYTES)
   ) u_dump_monitor (
      .clk        (clk),
      .rst_n      (rst_n),
      .save       (save),
      .busy       (busy),
      .txd        (txd),
      .exp_byte   (exp_byte),
      .byte_idx   (byte_idx),
      .byte_count (byte_count),
      .err_count  (err_count),
      .frame_errs (frame_errs)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // frame store, data valid the cycle after a read strobe
   initial begin
      logic              rd_seen;
      logic [ADDR_W-1:0] addr_seen;
      forever begin
         @(negedge clk);
         rd_seen   = mem_rd;
         addr_seen = mem_addr;
         @(posedge clk);
         #1;
         if (rd_seen)
            mem_rdata = word_at(32'(addr_seen));
      end
   end

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////
   task automatic pulse_save();
      @(posedge clk);
      #1 save = 1'b1;
      @(posedge clk);
      #1 save = 1'b0;
   endtask

   task automatic idle_gap(input int lo, input int hi);
      repeat ($urandom_range(hi, lo)) @(posedge clk);
      #1;
   endtask

   task automatic wait_dump_end();
      while (busy) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic log_result(input string name, input bit ok);
      tests_run++;
      if (ok) begin
         $display("test %0d %s: pass", tests_run, name);
      end else begin
         $display("test %0d %s: FAIL", tests_run, name);
         tests_failed++;
      end
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin
      int errs;
      void'($urandom(32'h3b91_01a0));
      rst_n        = 1'b0;
      save         = 1'b0;
      mem_rdata    = '0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      errs = err_count;
      idle_gap(20, 40);
      log_result("quiet after reset", err_count == errs && byte_count == 0 && !busy);

      errs = err_count;
      idle_gap(2, 10);
      pulse_save();
      wait_dump_end();
      log_result("single dump", err_count == errs && byte_count == FRAME_BYTES);

      // second save lands well inside the running dump
      errs = err_count;
      idle_gap(5, 15);
      pulse_save();
      idle_gap(100, 400);
      pulse_save();
      wait_dump_end();
      idle_gap(30, 60);
      log_result("save during dump ignored",
                 err_count == errs && byte_count == 2 * FRAME_BYTES && !busy);

      errs = err_count;
      idle_gap(5, 15);
      pulse_save();
      wait_dump_end();
      log_result("second dump", err_count == errs && byte_count == 3 * FRAME_BYTES);

      log_result("serial framing", frame_errs == 0);

      $display("tests %0d, failed %0d, bytes checked %0d, errors %0d",
               tests_run, tests_failed, byte_count, err_count);
      if (tests_failed == 0 && err_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout reached after %0d cycles, the dumps did not finish", cycles);
      $display("Something failed");
      $finish;
   end

endmodule
